// ==== design/secv_pkg.sv ====
// Shared widths, types and register map of the memory tagging subsystem, imported by every module
package secv_pkg;

  // ==========================================================
  // Core widths and data types
  // ==========================================================

  // Register width of the core
  parameter int XLEN = 32;

  // One register word, used for the pointer operand src1
  typedef logic [XLEN-1:0] xlen_t;

  // Major opcodes seen by the tagging unit
  // Only custom-0 is special, every other opcode is treated as a checked access
  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'b0000011,
    OPCODE_STORE    = 7'b0100011,
    OPCODE_CUSTOM_0 = 7'b0001011
  } opcode_t;

  // ==========================================================
  // Function-unit interface
  // ==========================================================

  // Request from the pipeline, held stable by the source until rdy
  typedef struct packed {
    logic    ena;
    opcode_t op;
    xlen_t   src1;
  } funit_in_t;

  // Completion pulse and error flag, err is only meaningful with rdy
  typedef struct packed {
    logic rdy;
    logic err;
  } funit_out_t;

  // Idle value of the function-unit outputs
  function automatic funit_out_t funit_out_default();
    funit_out_t res;
    res.rdy = 1'b0;
    res.err = 1'b0;
    return res;
  endfunction

  // ==========================================================
  // Configuration register port
  // ==========================================================

  parameter int CSR_ADR_WIDTH = 2;

  typedef logic [CSR_ADR_WIDTH-1:0] csr_adr_t;
  typedef logic [31:0]              csr_dat_t;

  // Register indices of the tagging configuration block
  parameter csr_adr_t CSR_CTRL    = 2'd0;
  parameter csr_adr_t CSR_ERR_ADR = 2'd1;
  parameter csr_adr_t CSR_ERR_CNT = 2'd2;
  parameter csr_adr_t CSR_STATUS  = 2'd3;

endpackage

// ==== design/memtag.sv ====
// Tagging unit that turns function-unit requests into tag-bus cycles and flags tag mismatches
`timescale 1ns/1ps

module memtag import secv_pkg::*; #(
  // Tag size in bits, taken from the top of the pointer
  parameter int TLEN        = 8,
  // Bytes covered by one tag
  parameter int GRANULARITY = 8,
  // Byte address width in bits
  parameter int ADR_WIDTH   = 10,
  // Tag memory address width in bits
  parameter int TADR_WIDTH  = 7
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Function-unit request and response
  input  funit_in_t             fu_i,
  output funit_out_t            fu_o,

  // Check enable from the register block and error event back to it
  input  logic                  check_en_i,
  output logic                  err_o,
  output logic [ADR_WIDTH-1:0]  err_adr_o,

  // Tag bus master side
  output logic                  tmem_cyc_o,
  output logic                  tmem_stb_o,
  output logic                  tmem_we_o,
  output logic [TADR_WIDTH-1:0] tmem_adr_o,
  output logic [TLEN-1:0]       tmem_dat_o,
  input  logic [TLEN-1:0]       tmem_dat_i,
  input  logic                  tmem_ack_i
);

  // ==========================================================
  // Pointer decode
  // ==========================================================

  // Byte address sits in the low bits of the pointer
  logic [ADR_WIDTH-1:0] mem_adr;
  // Tag sits in the top TLEN bits of the pointer
  logic [TLEN-1:0]      tag;
  // Set-tag request, every other opcode is a checked access
  logic                 is_set;

  assign mem_adr = fu_i.src1[ADR_WIDTH-1:0];
  assign tag     = fu_i.src1[XLEN-1:XLEN-TLEN];
  assign is_set  = (fu_i.op == OPCODE_CUSTOM_0);

  // ==========================================================
  // Bus sequencing
  // ==========================================================

  // Set once the strobe has been sampled, cleared by the acknowledge
  // While it is set the strobe stays low, so the ack cycle never starts a second access
  logic wait_q;
  logic rdy;
  logic mismatch;
  logic err;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_q <= 1'b0;
    end else if (tmem_ack_i || !fu_i.ena) begin
      // Access finished or the source withdrew, the next cycle may strobe again
      wait_q <= 1'b0;
    end else if (tmem_stb_o) begin
      wait_q <= 1'b1;
    end
  end

  // Cycle stays open for the whole request, the strobe only in its first cycle
  assign tmem_cyc_o = fu_i.ena;
  assign tmem_stb_o = fu_i.ena & ~wait_q;
  assign tmem_we_o  = fu_i.ena & is_set;

  // Granule index is the byte address divided by the granule size
  assign tmem_adr_o = TADR_WIDTH'(mem_adr / GRANULARITY);
  // Tag word is always written whole
  assign tmem_dat_o = is_set ? tag : '0;

  // ==========================================================
  // Completion and tag compare
  // ==========================================================

  // Completion is the acknowledge of our own outstanding access
  assign rdy      = wait_q & tmem_ack_i;
  // Returned tag is only valid in the ack cycle
  assign mismatch = (tmem_dat_i != tag);
  assign err      = rdy & ~is_set & check_en_i & mismatch;

  always_comb begin
    fu_o     = funit_out_default();
    fu_o.rdy = rdy;
    fu_o.err = err;
  end

  // Error event for the register block, same pulse as fu_o.err
  assign err_o     = err;
  assign err_adr_o = err ? mem_adr : '0;

  // ==========================================================
  // Assertions
  // ==========================================================

  // Completion always answers a strobe issued one cycle earlier
  a_rdy_with_ack : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    fu_o.rdy |-> tmem_ack_i && $past(tmem_stb_o)
  );

  // An error only completes a read access that was strobed one cycle earlier
  a_err_with_rdy : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    fu_o.err |-> fu_o.rdy && $past(tmem_stb_o && !tmem_we_o)
  );

  // The source keeps its request until the acknowledge arrives
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    tmem_stb_o |=> $stable(fu_i)
  );

endmodule

// ==== design/tag_mem.sv ====
// Tag memory slave holding one tag per granule, answering each strobe with a one-cycle acknowledge
`timescale 1ns/1ps

module tag_mem #(
  // Width of one stored tag
  parameter int TLEN       = 8,
  // Number of granule address bits
  parameter int TADR_WIDTH = 7
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Tag bus slave side
  input  logic                  cyc_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  logic [TADR_WIDTH-1:0] adr_i,
  input  logic [TLEN-1:0]       dat_i,
  output logic [TLEN-1:0]       dat_o,
  output logic                  ack_o
);

  // One entry for every granule in the address space
  localparam int DEPTH = 2 ** TADR_WIDTH;

  // ==========================================================
  // Storage and acknowledge
  // ==========================================================

  logic [TLEN-1:0] mem [DEPTH];
  logic            ack_q;
  logic [TLEN-1:0] dat_q;
  // Valid access in this cycle
  logic            access;

  // A strobe directly after an acknowledge is a new access, but
  // it is only taken once the acknowledge has dropped again
  assign access = cyc_i & stb_i & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // All granules start untagged
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
      if (access && we_i) begin
        mem[adr_i] <= dat_i;
      end
    end
  end

  // Read data captured with the strobe and presented with the acknowledge
  always_ff @(posedge clk_i) begin
    if (access) begin
      // Write returns the new tag, a read the stored one
      dat_q <= we_i ? dat_i : mem[adr_i];
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack_q;

  // ==========================================================
  // Assertions
  // ==========================================================

  // Acknowledge is a single-cycle pulse
  a_ack_no_repeat : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ack_o |=> !ack_o
  );

  // The master never strobes outside an open bus cycle
  a_stb_in_cyc : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    stb_i |-> cyc_i
  );

endmodule

// ==== design/memtag_csr.sv ====
// Configuration and status registers of the tagging unit, written and read through a strobe port
`timescale 1ns/1ps

module memtag_csr import secv_pkg::*; #(
  // Width of the captured byte address
  parameter int ADR_WIDTH = 10
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Register port
  input  logic                 cfg_we_i,
  input  csr_adr_t             cfg_adr_i,
  input  csr_dat_t             cfg_wdat_i,
  output csr_dat_t             cfg_rdat_o,

  // Error event from the tagging unit
  input  logic                 err_i,
  input  logic [ADR_WIDTH-1:0] err_adr_i,

  // Check enable towards the tagging unit
  output logic                 check_en_o
);

  // ==========================================================
  // Write decode
  // ==========================================================

  logic ctrl_we;
  // Clear request, bit 1 of a CTRL write
  logic clr;

  assign ctrl_we = cfg_we_i && (cfg_adr_i == CSR_CTRL);
  assign clr     = ctrl_we && cfg_wdat_i[1];

  // ==========================================================
  // Registers
  // ==========================================================

  logic                 check_en_q;
  logic [ADR_WIDTH-1:0] err_adr_q;
  logic                 err_vld_q;
  csr_dat_t             err_cnt_q;

  // Check enable comes out of reset set, so tagging is active by default
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      check_en_q <= 1'b1;
    end else if (ctrl_we) begin
      check_en_q <= cfg_wdat_i[0];
    end
  end

  // First-error capture, later errors leave it alone until a clear
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_adr_q <= '0;
      err_vld_q <= 1'b0;
    end else if (clr) begin
      // Clear wins over an error in the same cycle
      err_adr_q <= '0;
      err_vld_q <= 1'b0;
    end else if (err_i && !err_vld_q) begin
      err_adr_q <= err_adr_i;
      err_vld_q <= 1'b1;
    end
  end

  // Mismatch counter, sticks at all ones
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_cnt_q <= '0;
    end else if (clr) begin
      err_cnt_q <= '0;
    end else if (err_i && (err_cnt_q != '1)) begin
      err_cnt_q <= err_cnt_q + 1'b1;
    end
  end

  assign check_en_o = check_en_q;

  // ==========================================================
  // Read mux
  // ==========================================================

  always_comb begin
    cfg_rdat_o = '0;
    case (cfg_adr_i)
      // Clear bit is write-only and reads as zero
      CSR_CTRL:    cfg_rdat_o[0] = check_en_q;
      CSR_ERR_ADR: cfg_rdat_o    = csr_dat_t'(err_adr_q);
      CSR_ERR_CNT: cfg_rdat_o    = err_cnt_q;
      CSR_STATUS:  cfg_rdat_o[0] = err_vld_q;
      default:     cfg_rdat_o    = '0;
    endcase
  end

  // ==========================================================
  // Assertions
  // ==========================================================

  // Only a clear may lower the error count
  a_cnt_monotonic : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !clr |=> (err_cnt_q >= $past(err_cnt_q))
  );

endmodule

// ==== design/memtag_top.sv ====
// Top level of the tagging subsystem, sets the parameters and wires unit, tag memory and registers
`timescale 1ns/1ps

module memtag_top import secv_pkg::*; #(
  // Tag size in bits
  parameter int TLEN        = 8,
  // Bytes per tagged granule
  parameter int GRANULARITY = 8,
  // Byte address width
  parameter int ADR_WIDTH   = 10,
  // Granule index width, ADR_WIDTH less the granule offset bits
  parameter int TADR_WIDTH  = 7
) (
  input  logic       clk_i,
  input  logic       rst_n_i,

  // Function-unit port
  input  funit_in_t  fu_i,
  output funit_out_t fu_o,

  // Configuration register port
  input  logic       cfg_we_i,
  input  csr_adr_t   cfg_adr_i,
  input  csr_dat_t   cfg_wdat_i,
  output csr_dat_t   cfg_rdat_o
);

  // ==========================================================
  // Internal wiring
  // ==========================================================

  // Tag bus between the unit and the tag memory
  logic                  tmem_cyc;
  logic                  tmem_stb;
  logic                  tmem_we;
  logic [TADR_WIDTH-1:0] tmem_adr;
  logic [TLEN-1:0]       tmem_wdat;
  logic [TLEN-1:0]       tmem_rdat;
  logic                  tmem_ack;

  // Control and error event between the unit and the register block
  logic                  check_en;
  logic                  err;
  logic [ADR_WIDTH-1:0]  err_adr;

  // Tagging unit
  memtag #(
    .TLEN        (TLEN),
    .GRANULARITY (GRANULARITY),
    .ADR_WIDTH   (ADR_WIDTH),
    .TADR_WIDTH  (TADR_WIDTH)
  ) u_memtag (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .fu_i       (fu_i),
    .fu_o       (fu_o),
    .check_en_i (check_en),
    .err_o      (err),
    .err_adr_o  (err_adr),
    .tmem_cyc_o (tmem_cyc),
    .tmem_stb_o (tmem_stb),
    .tmem_we_o  (tmem_we),
    .tmem_adr_o (tmem_adr),
    .tmem_dat_o (tmem_wdat),
    .tmem_dat_i (tmem_rdat),
    .tmem_ack_i (tmem_ack)
  );

  // Tag storage, one entry per granule
  tag_mem #(
    .TLEN       (TLEN),
    .TADR_WIDTH (TADR_WIDTH)
  ) u_tag_mem (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cyc_i   (tmem_cyc),
    .stb_i   (tmem_stb),
    .we_i    (tmem_we),
    .adr_i   (tmem_adr),
    .dat_i   (tmem_wdat),
    .dat_o   (tmem_rdat),
    .ack_o   (tmem_ack)
  );

  // Check enable, error capture and count
  memtag_csr #(
    .ADR_WIDTH (ADR_WIDTH)
  ) u_memtag_csr (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_adr_i  (cfg_adr_i),
    .cfg_wdat_i (cfg_wdat_i),
    .cfg_rdat_o (cfg_rdat_o),
    .err_i      (err),
    .err_adr_i  (err_adr),
    .check_en_o (check_en)
  );

endmodule

// ==== sim/memtag_tb.sv ====
// Testbench for the tagging subsystem, runs directed and random tag checks against a reference model
`timescale 1ns/1ps

module memtag_tb import secv_pkg::*;;

  // ============================================================
  // Configuration and DUT
  // ============================================================

  // Same values as the top level sets for its sub-blocks
  localparam int TLEN        = 8;
  localparam int GRANULARITY = 8;
  localparam int ADR_WIDTH   = 10;
  localparam int TADR_WIDTH  = 7;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_RANDOM = 400;
  // Directed operations and register accesses, each at most two cycles
  localparam int NUM_STEPS  = NUM_RANDOM + 60;
  localparam int TIMEOUT_NS = NUM_STEPS * 2 * CLK_PERIOD + 500;
  // Longest wait for rdy before the request counts as lost
  localparam int RDY_LIMIT  = 8;

  logic       clk_i;
  logic       rst_n_i;
  funit_in_t  fu_i;
  funit_out_t fu_o;
  logic       cfg_we_i;
  csr_adr_t   cfg_adr_i;
  csr_dat_t   cfg_wdat_i;
  csr_dat_t   cfg_rdat_o;

  memtag_top #(
    .TLEN        (TLEN),
    .GRANULARITY (GRANULARITY),
    .ADR_WIDTH   (ADR_WIDTH),
    .TADR_WIDTH  (TADR_WIDTH)
  ) u_memtag_top (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .fu_i       (fu_i),
    .fu_o       (fu_o),
    .cfg_we_i   (cfg_we_i),
    .cfg_adr_i  (cfg_adr_i),
    .cfg_wdat_i (cfg_wdat_i),
    .cfg_rdat_o (cfg_rdat_o)
  );

  // ============================================================
  // Reference model and random source
  // ============================================================

  // One expected tag per granule, plus the register block state
  logic [TLEN-1:0]      model_tag [2**TADR_WIDTH];
  logic                 model_en;
  csr_dat_t             model_cnt;
  logic [ADR_WIDTH-1:0] model_adr;
  logic                 model_vld;

  logic [31:0] lfsr_state;
  // Expected err of the request in flight, read by the compare process
  logic        exp_err;
  int          fail_count;
  int          test_fail_base;
  int          tests_passed;
  int          tests_failed;

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one new bit per step
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // Tag in the top bits, byte address in the low bits
  function automatic xlen_t make_ptr(input logic [TLEN-1:0] tag, input logic [ADR_WIDTH-1:0] adr);
    xlen_t p;
    p = '0;
    p[XLEN-1 -: TLEN] = tag;
    p[ADR_WIDTH-1:0]  = adr;
    return p;
  endfunction

  // A checked access fails when the granule holds another tag
  function automatic logic expect_err(input opcode_t op, input xlen_t ptr);
    logic [TADR_WIDTH-1:0] gran;
    gran = TADR_WIDTH'(ptr[ADR_WIDTH-1:0] / GRANULARITY);
    if (op == OPCODE_CUSTOM_0) begin
      return 1'b0;
    end
    return model_en && (model_tag[gran] != ptr[XLEN-1 -: TLEN]);
  endfunction

  // ============================================================
  // Stimulus tasks
  // ============================================================

  // Issues one request, holds it until rdy and updates the model
  task automatic run_op(input opcode_t op, input logic [TLEN-1:0] tag,
                        input logic [ADR_WIDTH-1:0] adr);
    xlen_t ptr;
    int    cycles;
    logic  seen;
    ptr    = make_ptr(tag, adr);
    cycles = 0;
    seen   = 1'b0;
    @(posedge clk_i);
    exp_err = expect_err(op, ptr);
    fu_i.ena  <= 1'b1;
    fu_i.op   <= op;
    fu_i.src1 <= ptr;
    while (!seen && cycles < RDY_LIMIT) begin
      @(negedge clk_i);
      cycles++;
      seen = fu_o.rdy;
    end
    if (!seen) begin
      $display("No rdy came back for the request at byte address %0h within %0d cycles",
               adr, RDY_LIMIT);
      fail_count++;
    end else begin
      assert (cycles == 2) else begin
        $display("[ERROR] %0t: rdy after %0d cycles, expected 2", $time, cycles);
        fail_count++;
      end
      if (op == OPCODE_CUSTOM_0) begin
        model_tag[adr / GRANULARITY] = tag;
      end else if (exp_err) begin
        if (model_cnt != '1) model_cnt++;
        if (!model_vld) begin
          model_adr = adr;
          model_vld = 1'b1;
        end
      end
    end
  endtask

  // Drops the request once the last operation of a group is done
  task automatic end_ops();
    @(posedge clk_i);
    fu_i.ena <= 1'b0;
  endtask

  task automatic write_csr(input csr_adr_t adr, input csr_dat_t dat);
    @(posedge clk_i);
    cfg_we_i   <= 1'b1;
    cfg_adr_i  <= adr;
    cfg_wdat_i <= dat;
    @(posedge clk_i);
    cfg_we_i   <= 1'b0;
    if (adr == CSR_CTRL) begin
      model_en = dat[0];
      if (dat[1]) begin
        model_cnt = '0;
        model_adr = '0;
        model_vld = 1'b0;
      end
    end
  endtask

  // Read data is combinational, so it is checked in the middle of the cycle
  task automatic check_csr(input csr_adr_t adr, input csr_dat_t expected, input string name);
    @(posedge clk_i);
    cfg_we_i  <= 1'b0;
    cfg_adr_i <= adr;
    @(negedge clk_i);
    assert (cfg_rdat_o == expected) else begin
      $display("[ERROR] %0t: %s read %0h, expected %0h", $time, name, cfg_rdat_o, expected);
      fail_count++;
    end
  endtask

  task automatic finish_test(input string name);
    if (fail_count == test_fail_base) begin
      tests_passed++;
      $display("[RESULT] %s: PASS", name);
    end else begin
      tests_failed++;
      $display("[RESULT] %s: FAIL with %0d errors", name, fail_count - test_fail_base);
    end
    test_fail_base = fail_count;
  endtask

  // ============================================================
  // Compare process and watchdog
  // ============================================================

  // Every completion carries an err that must match the reference
  always @(negedge clk_i) begin
    if (rst_n_i && fu_o.rdy) begin
      assert (fu_o.err == exp_err) else begin
        $display("[ERROR] %0t: err %0b at byte address %0h, expected %0b",
                 $time, fu_o.err, fu_i.src1[ADR_WIDTH-1:0], exp_err);
        fail_count++;
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("The run timed out after %0d ns before all tests finished", TIMEOUT_NS);
    $display("test failed");
    $finish;
  end

  // ============================================================
  // Test sequence
  // ============================================================

  initial begin
    rst_n_i    = 1'b0;
    fu_i       = '0;
    cfg_we_i   = 1'b0;
    cfg_adr_i  = CSR_CTRL;
    cfg_wdat_i = '0;
    lfsr_state = 32'h9b13681e;
    exp_err    = 1'b0;
    fail_count = 0;
    test_fail_base = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    for (int i = 0; i < 2**TADR_WIDTH; i++) model_tag[i] = '0;
    model_en  = 1'b1;
    model_cnt = '0;
    model_adr = '0;
    model_vld = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Eight bytes of one granule share a single tag
    run_op(OPCODE_CUSTOM_0, 8'h5a, 10'h040);
    run_op(OPCODE_LOAD, 8'h5a, 10'h047);
    run_op(OPCODE_STORE, 8'h5a, 10'h043);
    end_ops();
    check_csr(CSR_ERR_CNT, 32'd0, "ERR_CNT");
    finish_test("1 granule sharing");

    // Wrong tag in a tagged granule
    run_op(OPCODE_LOAD, 8'h33, 10'h044);
    end_ops();
    check_csr(CSR_ERR_ADR, 32'h044, "ERR_ADR");
    check_csr(CSR_STATUS, 32'd1, "STATUS");
    check_csr(CSR_ERR_CNT, 32'd1, "ERR_CNT");
    finish_test("2 first mismatch capture");

    // Neighbor granule still holds tag 0, the capture keeps the first address
    run_op(OPCODE_LOAD, 8'h5a, 10'h048);
    end_ops();
    check_csr(CSR_ERR_CNT, 32'd2, "ERR_CNT");
    check_csr(CSR_ERR_ADR, 32'h044, "ERR_ADR");
    write_csr(CSR_CTRL, 32'h3);
    // Clear bit reads back as zero while the enable stays set
    check_csr(CSR_CTRL, 32'd1, "CTRL");
    check_csr(CSR_ERR_CNT, 32'd0, "ERR_CNT");
    check_csr(CSR_ERR_ADR, 32'd0, "ERR_ADR");
    check_csr(CSR_STATUS, 32'd0, "STATUS");
    finish_test("3 second mismatch and clear");

    // Checking off, mismatches complete quietly
    write_csr(CSR_CTRL, 32'h0);
    check_csr(CSR_CTRL, 32'd0, "CTRL");
    run_op(OPCODE_LOAD, 8'h77, 10'h041);
    run_op(OPCODE_LOAD, 8'h01, 10'h3f8);
    end_ops();
    check_csr(CSR_ERR_CNT, 32'd0, "ERR_CNT");
    write_csr(CSR_CTRL, 32'h1);
    run_op(OPCODE_LOAD, 8'h77, 10'h041);
    end_ops();
    check_csr(CSR_ERR_CNT, 32'd1, "ERR_CNT");
    finish_test("4 check enable");

    // Requests held straight after rdy, each must still take two cycles
    write_csr(CSR_CTRL, 32'h3);
    run_op(OPCODE_CUSTOM_0, 8'h11, 10'h100);
    run_op(OPCODE_LOAD, 8'h11, 10'h107);
    run_op(OPCODE_LOAD, 8'h12, 10'h100);
    run_op(OPCODE_STORE, 8'h11, 10'h101);
    end_ops();
    check_csr(CSR_ERR_CNT, 32'd1, "ERR_CNT");
    finish_test("5 back-to-back timing");

    // Two-bit tags make matches and mismatches both common
    write_csr(CSR_CTRL, 32'h3);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      if (take_bits(1) == 32'd1) begin
        run_op(OPCODE_CUSTOM_0, TLEN'(take_bits(2)), ADR_WIDTH'(take_bits(ADR_WIDTH)));
      end else begin
        run_op(OPCODE_LOAD, TLEN'(take_bits(2)), ADR_WIDTH'(take_bits(ADR_WIDTH)));
      end
    end
    end_ops();
    check_csr(CSR_ERR_CNT, model_cnt, "ERR_CNT");
    check_csr(CSR_ERR_ADR, csr_dat_t'(model_adr), "ERR_ADR");
    check_csr(CSR_STATUS, csr_dat_t'(model_vld), "STATUS");
    finish_test("6 random mix");

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, fail_count);
    if (fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
design/secv_pkg.sv
design/memtag.sv
design/tag_mem.sv
design/memtag_csr.sv
design/memtag_top.sv
sim/memtag_tb.sv
